//--- blake_settings.svh
// shared widths, counts and fixed message words of the BLAKE-256 nonce tester
// include in any file that uses these macros
`ifndef BLAKE_SETTINGS_SVH
`define BLAKE_SETTINGS_SVH

`define BLAKE_WORD_BITS   32
`define BLAKE_ROUNDS      8
`define BLAKE_HALF_ROUNDS (2 * `BLAKE_ROUNDS)
`define BLAKE_JOB_BITS    384

// bit count of the 80-byte header, goes into v12 and v13
`define BLAKE_COUNT       32'h0000_0280

// message words 4, 13 and 15
`define BLAKE_PAD_HI      32'h8000_0000
`define BLAKE_PAD_ONE     32'h0000_0001
`define BLAKE_PAD_LEN     32'h0000_0280

// two stages per half-round plus the match register
`define BLAKE_LATENCY     (2 * `BLAKE_HALF_ROUNDS + 1)

`endif

//--- blake_pkg.sv
// types, constants and the state setup shared by the BLAKE-256 pipeline
// referenced by scoped names from the RTL and the testbench
`include "blake_settings.svh"

package blake_pkg;

   typedef logic [`BLAKE_WORD_BITS-1:0] word_t;
   typedef word_t [15:0] state_t;
   typedef word_t [7:0] mid_t;
   typedef word_t [2:0] msg_t;

   // mid[7] sits at the top, init_nonce at the bottom
   typedef struct packed {
      mid_t  mid;
      msg_t  msg;
      word_t init_nonce;
   } job_s;

   // shifted as one vector, read back as words
   typedef union packed {
      logic [`BLAKE_JOB_BITS-1:0] bits;
      job_s                       words;
   } job_u;

   localparam word_t const_c [16] = '{
      32'h243F_6A88, 32'h85A3_08D3, 32'h1319_8A2E, 32'h0370_7344,
      32'hA409_3822, 32'h299F_31D0, 32'h082E_FA98, 32'hEC4E_6C89,
      32'h4528_21E6, 32'h38D0_1377, 32'hBE54_66CF, 32'h34E9_0C6C,
      32'hC0AC_29B7, 32'hC97C_50DD, 32'h3F84_D5B5, 32'hB547_0917
   };

   // one row per round, nibble k is the k-th message index
   localparam logic [0:15][3:0] sigma_c [10] = '{
      64'h0123_4567_89AB_CDEF,
      64'hEA48_9FD6_1C02_B753,
      64'hB8C0_52FD_AE36_7194,
      64'h7931_DCBE_265A_40F8,
      64'h9057_24AF_E1BC_683D,
      64'h2C6A_0B83_4D75_FE19,
      64'hC51F_ED4A_0763_928B,
      64'hDB7E_C139_50F4_862A,
      64'h6FE9_B308_C2D7_14A5,
      64'hA284_7615_FB9E_3CD0
   };

   // salt is zero and the high counter word too
   function automatic state_t init_state(input mid_t h);
      state_t v;
      for (int i = 0; i < 8; i++) begin
         v[i] = h[i];
      end
      for (int i = 0; i < 4; i++) begin
         v[8 + i] = const_c[i];
      end
      v[12] = const_c[4] ^ `BLAKE_COUNT;
      v[13] = const_c[5] ^ `BLAKE_COUNT;
      v[14] = const_c[6];
      v[15] = const_c[7];
      return v;
   endfunction

endpackage

//--- blake_job_loader.sv
// serial job register, one bit per clock while shift_i is high, MSB first
// the rest of the core reads the same register as words
`timescale 1ns/1ps

module blake_job_loader (
   input  logic              clk,
   input  logic              shift_i,
   input  logic              din_i,
   output blake_pkg::job_u   job_o,
   output blake_pkg::word_t  init_nonce_o
);

   localparam int job_bits = $bits(blake_pkg::job_u);

   blake_pkg::job_u job_q;

   // first bit in ends up at the top of the midstate
   always_ff @(posedge clk) begin
      if (shift_i) begin
         job_q.bits <= {job_q.bits[job_bits-2:0], din_i};
      end
   end

   assign job_o        = job_q;
   assign init_nonce_o = job_q.words.init_nonce;

endmodule

//--- blake_g.sv
// BLAKE G function on four state words, split over two register stages
// msg_b_i is expected one cycle after msg_a_i
`timescale 1ns/1ps

module blake_g (
   input  logic              clk,
   input  blake_pkg::word_t  a_i,
   input  blake_pkg::word_t  b_i,
   input  blake_pkg::word_t  c_i,
   input  blake_pkg::word_t  d_i,
   input  blake_pkg::word_t  msg_a_i,
   input  blake_pkg::word_t  msg_b_i,
   output blake_pkg::word_t  a_o,
   output blake_pkg::word_t  b_o,
   output blake_pkg::word_t  c_o,
   output blake_pkg::word_t  d_o
);

   localparam int w = $bits(blake_pkg::word_t);

   blake_pkg::word_t a1, b1, c1, d1;
   blake_pkg::word_t a_q, b_q, c_q, d_q;
   blake_pkg::word_t a2, b2, c2, d2;

   function automatic blake_pkg::word_t rotr(input blake_pkg::word_t x, input int n);
      return (x >> n) | (x << (w - n));
   endfunction

   // stage 1, rotations 16 and 12
   always_comb begin
      a1 = a_i + b_i + msg_a_i;
      d1 = rotr(d_i ^ a1, 16);
      c1 = c_i + d1;
      b1 = rotr(b_i ^ c1, 12);
   end

   always_ff @(posedge clk) begin
      a_q <= a1;
      b_q <= b1;
      c_q <= c1;
      d_q <= d1;
   end

   // stage 2, rotations 8 and 7
   always_comb begin
      a2 = a_q + b_q + msg_b_i;
      d2 = rotr(d_q ^ a2, 8);
      c2 = c_q + d2;
      b2 = rotr(b_q ^ c2, 7);
   end

   always_ff @(posedge clk) begin
      a_o <= a2;
      b_o <= b2;
      c_o <= c2;
      d_o <= d2;
   end

endmodule

//--- blake_half_round.sv
// one column or diagonal step of the unrolled BLAKE-256 pipeline
// four G units, fixed two-cycle latency, nonce and valid ride alongside
`timescale 1ns/1ps
`include "blake_settings.svh"

module blake_half_round #(
   parameter int step = 0
) (
   input  logic               clk,
   input  logic               rst_n_i,
   input  blake_pkg::state_t  state_i,
   input  blake_pkg::msg_t    msg_i,
   input  blake_pkg::word_t   nonce_i,
   input  logic               valid_i,
   output blake_pkg::state_t  state_o,
   output blake_pkg::word_t   nonce_o,
   output logic               valid_o
);

   // sigma repeats after ten rounds
   localparam int row  = (step / 2) % 10;
   localparam int diag = step % 2;

   blake_pkg::word_t nonce_q;
   logic             valid_q;
   blake_pkg::word_t msg_a [4];
   blake_pkg::word_t msg_b [4];
   blake_pkg::word_t g_a [4];
   blake_pkg::word_t g_b [4];
   blake_pkg::word_t g_c [4];
   blake_pkg::word_t g_d [4];

   // words 0..2 come from the job, 3 is the nonce, the rest is padding
   function automatic blake_pkg::word_t msg_word(input logic [3:0] idx,
                                                 input blake_pkg::msg_t m,
                                                 input blake_pkg::word_t nonce);
      case (idx)
         4'd0, 4'd1, 4'd2: msg_word = m[idx[1:0]];
         4'd3:             msg_word = nonce;
         4'd4:             msg_word = `BLAKE_PAD_HI;
         4'd13:            msg_word = `BLAKE_PAD_ONE;
         4'd15:            msg_word = `BLAKE_PAD_LEN;
         default:          msg_word = '0;
      endcase
   endfunction

   for (genvar g = 0; g < 4; g++) begin : g_unit
      localparam int gi = g + 4 * diag;
      localparam logic [3:0] idx_a = blake_pkg::sigma_c[row][2 * gi];
      localparam logic [3:0] idx_b = blake_pkg::sigma_c[row][2 * gi + 1];

      // each message word is xored with its partner's constant
      assign msg_a[g] = msg_word(idx_a, msg_i, nonce_i) ^ blake_pkg::const_c[idx_b];
      assign msg_b[g] = msg_word(idx_b, msg_i, nonce_q) ^ blake_pkg::const_c[idx_a];

      blake_g u_g (
         .clk     (clk),
         .a_i     (state_i[g]),
         .b_i     (state_i[4 + (g + diag) % 4]),
         .c_i     (state_i[8 + (g + 2 * diag) % 4]),
         .d_i     (state_i[12 + (g + 3 * diag) % 4]),
         .msg_a_i (msg_a[g]),
         .msg_b_i (msg_b[g]),
         .a_o     (g_a[g]),
         .b_o     (g_b[g]),
         .c_o     (g_c[g]),
         .d_o     (g_d[g])
      );
   end

   // results go back to the words they came from
   always_comb begin
      for (int g = 0; g < 4; g++) begin
         state_o[g]                      = g_a[g];
         state_o[4 + (g + diag) % 4]      = g_b[g];
         state_o[8 + (g + 2 * diag) % 4]  = g_c[g];
         state_o[12 + (g + 3 * diag) % 4] = g_d[g];
      end
   end

   always_ff @(posedge clk) begin
      nonce_q <= nonce_i;
      nonce_o <= nonce_q;
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
         valid_o <= 1'b0;
      end else begin
         valid_q <= valid_i;
         valid_o <= valid_q;
      end
   end

endmodule

//--- blake_match.sv
// tests the last hash word for zeros in its low match_bits bits
// registers the hit flag and the nonce that goes with it
`timescale 1ns/1ps

module blake_match #(
   parameter int match_bits = 32
) (
   input  logic               clk,
   input  logic               rst_n_i,
   input  blake_pkg::word_t   mid7_i,
   input  blake_pkg::state_t  state_i,
   input  blake_pkg::word_t   nonce_i,
   input  logic               valid_i,
   output logic               match_o,
   output blake_pkg::word_t   match_nonce_o
);

   blake_pkg::word_t h7;

   // finalization of h7, salt is zero
   assign h7 = mid7_i ^ state_i[7] ^ state_i[15];

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         match_o <= 1'b0;
      end else begin
         match_o <= valid_i && (h7[match_bits-1:0] == '0);
      end
   end

   always_ff @(posedge clk) begin
      match_nonce_o <= nonce_i;
   end

endmodule

//--- blake_core.sv
// BLAKE-256 nonce tester, 8 rounds from a loaded midstate, one nonce per clock
// match_o reports the nonce sampled 33 edges earlier
`timescale 1ns/1ps
`include "blake_settings.svh"

module blake_core #(
   parameter int match_bits = 32
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic              shift_i,
   input  logic              din_i,
   input  blake_pkg::word_t  nonce_i,
   input  logic              nonce_valid_i,
   output blake_pkg::word_t  init_nonce_o,
   output logic              match_o,
   output blake_pkg::word_t  match_nonce_o
);

   localparam int steps = `BLAKE_HALF_ROUNDS;

   blake_pkg::job_u   job;
   blake_pkg::state_t chain_state [steps + 1];
   blake_pkg::word_t  chain_nonce [steps + 1];
   logic              chain_valid [steps + 1];

   blake_job_loader u_loader (
      .clk          (clk),
      .shift_i      (shift_i),
      .din_i        (din_i),
      .job_o        (job),
      .init_nonce_o (init_nonce_o)
   );

   assign chain_state[0] = blake_pkg::init_state(job.words.mid);
   assign chain_nonce[0] = nonce_i;
   assign chain_valid[0] = nonce_valid_i;

   for (genvar i = 0; i < steps; i++) begin : g_step
      blake_half_round #(
         .step (i)
      ) u_half_round (
         .clk     (clk),
         .rst_n_i (rst_n_i),
         .state_i (chain_state[i]),
         .msg_i   (job.words.msg),
         .nonce_i (chain_nonce[i]),
         .valid_i (chain_valid[i]),
         .state_o (chain_state[i + 1]),
         .nonce_o (chain_nonce[i + 1]),
         .valid_o (chain_valid[i + 1])
      );
   end

   blake_match #(
      .match_bits (match_bits)
   ) u_match (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .mid7_i        (job.words.mid[7]),
      .state_i       (chain_state[steps]),
      .nonce_i       (chain_nonce[steps]),
      .valid_i       (chain_valid[steps]),
      .match_o       (match_o),
      .match_nonce_o (match_nonce_o)
   );

endmodule

//--- blake_properties.sv
// port-level assertions for the nonce tester, bound into blake_core
`timescale 1ns/1ps
`include "blake_settings.svh"

module blake_properties (
   input logic              clk,
   input logic              rst_n_i,
   input blake_pkg::word_t  nonce_i,
   input logic              nonce_valid_i,
   input logic              match_o,
   input blake_pkg::word_t  match_nonce_o
);

   int unsigned since_reset;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         since_reset <= 0;
      end else if (since_reset < 1000) begin
         since_reset <= since_reset + 1;
      end
   end

   reset_quiet: assert property (@(posedge clk) !rst_n_i |=> !match_o)
      else $error("match_o set while in reset");

   // pipeline still holds only cleared valid bits
   fill_quiet: assert property (@(posedge clk)
      rst_n_i && since_reset < `BLAKE_LATENCY |-> !match_o)
      else $error("match_o set before the pipeline filled");

   known: assert property (@(posedge clk) disable iff (!rst_n_i) !$isunknown(match_o))
      else $error("match_o unknown after reset");

   // report seen at an edge belongs to the nonce one latency of edges back
   nonce_pair: assert property (@(posedge clk) disable iff (!rst_n_i)
      match_o |-> $past(nonce_valid_i, `BLAKE_LATENCY)
               && match_nonce_o == $past(nonce_i, `BLAKE_LATENCY))
      else $error("match_nonce_o does not belong to a valid nonce");

endmodule

//--- blake_tb_clk.sv
// clock and reset source for the nonce tester testbench
`timescale 1ns/1ps

module blake_tb_clk #(
   parameter real period       = 8.0,
   parameter int  reset_cycles = 16
) (
   output logic clk,
   output logic rst_n_o
);

   initial begin
      clk = 1'b0;
      forever #(period / 2.0) clk = ~clk;
   end

   // released on a rising edge like the rest of the stimulus
   initial begin
      rst_n_o = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      rst_n_o <= 1'b1;
   end

endmodule

//--- blake_tb.sv
// testbench for the BLAKE-256 nonce tester with its own model of the hash
// loads random jobs, streams random nonces and checks every match report
`timescale 1ns/1ps
`include "blake_settings.svh"

module blake_tb;

   localparam real clk_period     = 8.0;
   localparam int  tb_match_bits  = 8;
   localparam int  idle_cycles    = 40;
   localparam int  n_back_to_back = 1000;
   localparam int  n_gapped       = 600;
   localparam int  n_second       = 500;
   localparam int  watchdog_cycles = 16 + idle_cycles + 2 * (`BLAKE_JOB_BITS + 2)
      + n_back_to_back + n_gapped + n_second + 3 * (`BLAKE_LATENCY + 2) + 200;

   // state words of each G, columns first, then diagonals
   localparam int g_pos [8][4] = '{
      '{0, 4, 8, 12}, '{1, 5, 9, 13}, '{2, 6, 10, 14}, '{3, 7, 11, 15},
      '{0, 5, 10, 15}, '{1, 6, 11, 12}, '{2, 7, 8, 13}, '{3, 4, 9, 14}
   };

   logic             clk;
   logic             rst_n_i;
   logic             shift_i;
   logic             din_i;
   blake_pkg::word_t nonce_i;
   logic             nonce_valid_i;
   blake_pkg::word_t init_nonce_o;
   logic             match_o;
   blake_pkg::word_t match_nonce_o;

   blake_pkg::job_u  job_model;
   logic [31:0]      lfsr = 32'ha810_3722;
   logic             exp_hit_q [$];
   blake_pkg::word_t exp_nonce_q [$];
   int               bit_errs = 0;
   int               word_errs = 0;
   int               other_errs = 0;
   int               hits_seen = 0;

   blake_tb_clk #(
      .period       (clk_period),
      .reset_cycles (16)
   ) u_clk (
      .clk     (clk),
      .rst_n_o (rst_n_i)
   );

   blake_core #(
      .match_bits (tb_match_bits)
   ) dut0 (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .shift_i       (shift_i),
      .din_i         (din_i),
      .nonce_i       (nonce_i),
      .nonce_valid_i (nonce_valid_i),
      .init_nonce_o  (init_nonce_o),
      .match_o       (match_o),
      .match_nonce_o (match_nonce_o)
   );

   bind blake_core blake_properties u_props (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .nonce_i       (nonce_i),
      .nonce_valid_i (nonce_valid_i),
      .match_o       (match_o),
      .match_nonce_o (match_nonce_o)
   );

   // Galois form, taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic blake_pkg::word_t random_bits(input int n);
      blake_pkg::word_t val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         val  = {val[30:0], lfsr[0]};
      end
      return val;
   endfunction

   function automatic blake_pkg::word_t rotate_right(input blake_pkg::word_t x, input int n);
      return (x >> n) | (x << (32 - n));
   endfunction

   // plain BLAKE-256 compression, reduced rounds, only h7 kept
   function automatic blake_pkg::word_t ref_h7(input blake_pkg::job_u job,
                                               input blake_pkg::word_t nonce);
      blake_pkg::word_t v [16];
      blake_pkg::word_t m [16];
      blake_pkg::word_t a, b, c, d;
      logic [3:0]       s0, s1;
      for (int i = 0; i < 16; i++) begin
         m[i] = '0;
      end
      for (int i = 0; i < 3; i++) begin
         m[i] = job.words.msg[i];
      end
      m[3]  = nonce;
      m[4]  = `BLAKE_PAD_HI;
      m[13] = `BLAKE_PAD_ONE;
      m[15] = `BLAKE_PAD_LEN;
      for (int i = 0; i < 8; i++) begin
         v[i]     = job.words.mid[i];
         v[8 + i] = blake_pkg::const_c[i];
      end
      // t0 into v12 and v13, t1 is zero
      v[12] ^= `BLAKE_COUNT;
      v[13] ^= `BLAKE_COUNT;
      for (int r = 0; r < `BLAKE_ROUNDS; r++) begin
         for (int g = 0; g < 8; g++) begin
            s0 = blake_pkg::sigma_c[r % 10][2 * g];
            s1 = blake_pkg::sigma_c[r % 10][2 * g + 1];
            a = v[g_pos[g][0]];
            b = v[g_pos[g][1]];
            c = v[g_pos[g][2]];
            d = v[g_pos[g][3]];
            a = a + b + (m[s0] ^ blake_pkg::const_c[s1]);
            d = rotate_right(d ^ a, 16);
            c = c + d;
            b = rotate_right(b ^ c, 12);
            a = a + b + (m[s1] ^ blake_pkg::const_c[s0]);
            d = rotate_right(d ^ a, 8);
            c = c + d;
            b = rotate_right(b ^ c, 7);
            v[g_pos[g][0]] = a;
            v[g_pos[g][1]] = b;
            v[g_pos[g][2]] = c;
            v[g_pos[g][3]] = d;
         end
      end
      return job.words.mid[7] ^ v[7] ^ v[15];
   endfunction

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         bit_errs++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_word(input string name, input blake_pkg::word_t got,
                             input blake_pkg::word_t exp);
      if (got !== exp) begin
         word_errs++;
         $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // starts and ends on a rising edge
   task automatic load_job();
      blake_pkg::word_t b;
      blake_pkg::word_t last_word;
      last_word = '0;
      for (int i = 0; i < `BLAKE_JOB_BITS; i++) begin
         b = random_bits(1);
         shift_i <= 1'b1;
         din_i   <= b[0];
         job_model.bits[`BLAKE_JOB_BITS - 1 - i] = b[0];
         last_word = {last_word[30:0], b[0]};
         @(posedge clk);
      end
      shift_i <= 1'b0;
      @(negedge clk);
      check_word("init_nonce_o", init_nonce_o, last_word);
      @(posedge clk);
   endtask

   task automatic send_nonces(input int count, input logic gaps);
      for (int i = 0; i < count; i++) begin
         nonce_i       <= random_bits(32);
         nonce_valid_i <= gaps ? (random_bits(1) != '0) : 1'b1;
         @(posedge clk);
      end
      nonce_valid_i <= 1'b0;
   endtask

   task automatic drain();
      repeat (`BLAKE_LATENCY + 2) @(posedge clk);
   endtask

   // outputs are read at the falling edge, inputs are those of the next rising edge
   always @(negedge clk) begin
      logic             exp_hit;
      blake_pkg::word_t exp_nonce;
      blake_pkg::word_t h;
      if (exp_hit_q.size() >= `BLAKE_LATENCY) begin
         exp_hit   = exp_hit_q.pop_front();
         exp_nonce = exp_nonce_q.pop_front();
         check_bit("match_o", match_o, exp_hit);
         if (exp_hit && match_o === 1'b1) begin
            check_word("match_nonce_o", match_nonce_o, exp_nonce);
            hits_seen++;
         end
      end else begin
         check_bit("match_o", match_o, 1'b0);
      end
      exp_hit = 1'b0;
      if (nonce_valid_i && rst_n_i) begin
         h       = ref_h7(job_model, nonce_i);
         exp_hit = (h[tb_match_bits-1:0] == '0);
      end
      exp_hit_q.push_back(exp_hit);
      exp_nonce_q.push_back(nonce_i);
   end

   initial begin
      shift_i       = 1'b0;
      din_i         = 1'b0;
      nonce_i       = '0;
      nonce_valid_i = 1'b0;
      wait (rst_n_i === 1'b1);
      @(posedge clk);
      // nothing in flight yet, match_o has to stay low
      repeat (idle_cycles) @(posedge clk);
      load_job();
      send_nonces(n_back_to_back, 1'b0);
      send_nonces(n_gapped, 1'b1);
      drain();
      load_job();
      send_nonces(n_second, 1'b0);
      drain();
      if (hits_seen == 0) begin
         other_errs++;
         $display("no match was reported, the hit path was never exercised");
      end
      $display("errors: %0d match flag, %0d word, %0d other, %0d hits checked",
               bit_errs, word_errs, other_errs, hits_seen);
      if (bit_errs + word_errs + other_errs == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   initial begin
      #(watchdog_cycles * clk_period);
      $display("timeout, the test sequence did not complete in time");
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- src.f
+incdir+.
blake_pkg.sv
blake_job_loader.sv
blake_g.sv
blake_half_round.sv
blake_match.sv
blake_core.sv
blake_properties.sv
blake_tb_clk.sv
blake_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the nonce tester testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module blake_tb -o blake_tb_sim

out=$(./obj_dir/blake_tb_sim)
echo "$out"

if grep -qx "NO ERRORS" <<< "$out"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
